//--- include/mem_config.svh
`ifndef MEM_CONFIG_SVH
`define MEM_CONFIG_SVH

// data path width in bits
`define MEM_WORD_BITS 32

// ram size in words
// a power of two, so the word index simply wraps
`define MEM_DEPTH_WORDS 256

`endif

//--- hw/memPkg.sv
`default_nettype none

`include "mem_config.svh"

package memPkg;

    // data or address word
    typedef logic [`MEM_WORD_BITS-1:0] word_t;

    // one enable per byte lane
    typedef logic [`MEM_WORD_BITS/8-1:0] strobe_t;

    typedef enum logic [1:0] {
        MSIZE1,
        MSIZE2,
        MSIZE4
    } msize_e;

    // address error on load or on store
    typedef enum logic [1:0] {
        EXC_NONE,
        EXC_ADEL,
        EXC_ADES
    } excCode_e;

    typedef enum logic [1:0] {
        IDLE,
        REQ,
        WAITDROP,
        DONE
    } laneState_e;

    typedef enum logic [1:0] {
        FREE,
        GRANT1,
        GRANT0
    } arbState_e;

endpackage

`default_nettype wire

//--- hw/dbusIf.sv
`timescale 1ns/10ps
`default_nettype none

interface dbusIf;
    import memPkg::*;

    // request side, held stable while req is high
    logic    req;
    word_t   addr;
    word_t   wdata;
    strobe_t strobe;
    logic    write;

    // response, rdata only meaningful while ack is high
    logic    ack;
    word_t   rdata;

    modport master (
        output req,
        output addr,
        output wdata,
        output strobe,
        output write,
        input  ack,
        input  rdata
    );

    modport slave (
        input  req,
        input  addr,
        input  wdata,
        input  strobe,
        input  write,
        output ack,
        output rdata
    );

endinterface

`default_nettype wire

//--- hw/memLane.sv
`timescale 1ns/10ps
`default_nettype none

module memLane (
    input  wire                clk,
    input  wire                arstN,
    input  wire                start,
    input  wire                suppress,
    input  wire                valid,
    input  wire                isLoad,
    input  wire                isStore,
    input  wire memPkg::msize_e size,
    input  wire memPkg::word_t addr,
    input  wire memPkg::word_t wdata,
    output logic               fault,
    output logic               done,
    output memPkg::word_t      rdata,
    output memPkg::excCode_e   excp,
    dbusIf.master              bus
);
    import memPkg::*;

    laneState_e state;
    logic       take;
    logic       validQ;
    logic       isLoadQ;
    logic       isStoreQ;
    msize_e     sizeQ;
    word_t      addrQ;
    word_t      wdataQ;
    word_t      rdataQ;
    logic       isAccess;
    logic       isWrite;
    logic       misalign;
    logic       needBus;
    strobe_t    strobe;
    word_t      wordOut;
    word_t      shifted;
    word_t      loadWord;

    // new instruction accepted only between pairs
    assign take = start && (state == IDLE || state == DONE);

    assign isAccess = validQ && (isLoadQ || isStoreQ);
    assign isWrite  = isStoreQ && !isLoadQ;

    always_comb begin
        case (sizeQ)
            MSIZE2:  misalign = addrQ[0];
            MSIZE4:  misalign = |addrQ[1:0];
            default: misalign = 1'b0;
        endcase
    end

    assign fault   = isAccess && misalign && !suppress;
    assign needBus = isAccess && !misalign && !suppress;

    always_comb begin
        excp = EXC_NONE;
        if (fault) begin
            excp = isLoadQ ? EXC_ADEL : EXC_ADES;
        end
    end

    // byte and half data replicated across the word, strobe picks the lane
    always_comb begin
        case (sizeQ)
            MSIZE1: begin
                strobe  = strobe_t'(1) << addrQ[1:0];
                wordOut = {4{wdataQ[7:0]}};
            end
            MSIZE2: begin
                strobe  = addrQ[1] ? 4'b1100 : 4'b0011;
                wordOut = {2{wdataQ[15:0]}};
            end
            default: begin
                strobe  = '1;
                wordOut = wdataQ;
            end
        endcase
    end

    // right-align the loaded bytes, zero the rest
    always_comb begin
        shifted = bus.rdata >> {addrQ[1:0], 3'b000};
        case (sizeQ)
            MSIZE1:  loadWord = word_t'(shifted[7:0]);
            MSIZE2:  loadWord = word_t'(shifted[15:0]);
            default: loadWord = shifted;
        endcase
    end

    assign bus.req    = (state == REQ) && needBus;
    assign bus.addr   = addrQ;
    assign bus.wdata  = wordOut;
    assign bus.strobe = isWrite ? strobe : '0;
    assign bus.write  = isWrite;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state    <= IDLE;
            validQ   <= 1'b0;
            isLoadQ  <= 1'b0;
            isStoreQ <= 1'b0;
        end else begin
            case (state)
                IDLE, DONE: begin
                    if (take) begin
                        state    <= REQ;
                        validQ   <= valid;
                        isLoadQ  <= isLoad;
                        isStoreQ <= isStore;
                    end
                end
                REQ: begin
                    // faulting, suppressed or idle lanes skip the bus
                    if (!needBus) begin
                        state <= DONE;
                    end else if (bus.ack) begin
                        state <= WAITDROP;
                    end
                end
                WAITDROP: begin
                    if (!bus.ack) begin
                        state <= DONE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            sizeQ  <= size;
            addrQ  <= addr;
            wdataQ <= wdata;
            rdataQ <= '0;
        end else if (state == REQ && bus.ack && !isWrite) begin
            rdataQ <= loadWord;
        end
    end

    assign done  = (state == DONE);
    assign rdata = rdataQ;

endmodule

`default_nettype wire

//--- hw/dbusArbiter.sv
`timescale 1ns/10ps
`default_nettype none

module dbusArbiter (
    input wire    clk,
    input wire    arstN,
    dbusIf.slave  older,
    dbusIf.slave  younger,
    dbusIf.master mem
);
    import memPkg::*;

    arbState_e state;
    arbState_e nextState;

    // older lane always wins, keeps program order for same-word pairs
    always_comb begin
        nextState = state;
        case (state)
            FREE: begin
                if (older.req) begin
                    nextState = GRANT1;
                end else if (younger.req) begin
                    nextState = GRANT0;
                end
            end
            // release only after the full four-phase cycle
            GRANT1: begin
                if (!older.req && !mem.ack) begin
                    nextState = FREE;
                end
            end
            GRANT0: begin
                if (!younger.req && !mem.ack) begin
                    nextState = FREE;
                end
            end
            default: nextState = FREE;
        endcase
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state <= FREE;
        end else begin
            state <= nextState;
        end
    end

    always_comb begin
        mem.req       = 1'b0;
        mem.addr      = older.addr;
        mem.wdata     = older.wdata;
        mem.strobe    = older.strobe;
        mem.write     = older.write;
        older.ack     = 1'b0;
        older.rdata   = '0;
        younger.ack   = 1'b0;
        younger.rdata = '0;
        case (state)
            GRANT1: begin
                mem.req     = older.req;
                older.ack   = mem.ack;
                older.rdata = mem.rdata;
            end
            GRANT0: begin
                mem.req       = younger.req;
                mem.addr      = younger.addr;
                mem.wdata     = younger.wdata;
                mem.strobe    = younger.strobe;
                mem.write     = younger.write;
                younger.ack   = mem.ack;
                younger.rdata = mem.rdata;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

//--- hw/dataRam.sv
`timescale 1ns/10ps
`default_nettype none

`include "mem_config.svh"

module dataRam (
    input wire   clk,
    input wire   arstN,
    dbusIf.slave port
);
    import memPkg::*;

    localparam int IDX_BITS = $clog2(`MEM_DEPTH_WORDS);

    word_t               ram [`MEM_DEPTH_WORDS];
    logic [IDX_BITS-1:0] idx;
    logic                ack;
    logic                accept;
    word_t               rdataQ;

    // byte address to word index, high bits dropped so it wraps
    assign idx = port.addr[IDX_BITS+1:2];

    // one access per request, never while the previous ack is still up
    assign accept = port.req && !ack;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            ack <= 1'b0;
            for (int w = 0; w < `MEM_DEPTH_WORDS; w++) begin
                ram[w] <= '0;
            end
        end else if (accept) begin
            ack <= 1'b1;
            if (port.write) begin
                for (int b = 0; b < `MEM_WORD_BITS/8; b++) begin
                    if (port.strobe[b]) begin
                        ram[idx][8*b +: 8] <= port.wdata[8*b +: 8];
                    end
                end
            end
        end else if (ack && !port.req) begin
            ack <= 1'b0;
        end
    end

    // read before write on the same edge
    always_ff @(posedge clk) begin
        if (accept) begin
            rdataQ <= ram[idx];
        end
    end

    assign port.ack   = ack;
    assign port.rdata = rdataQ;

endmodule

`default_nettype wire

//--- hw/pairControl.sv
`timescale 1ns/10ps
`default_nettype none

module pairControl (
    input  wire  clk,
    input  wire  arstN,
    input  wire  pairReq,
    input  wire  fault1,
    input  wire  fault0,
    input  wire  done1,
    input  wire  done0,
    output logic pairAck,
    output logic start,
    output logic suppress0,
    output logic excpM
);

    logic reqQ;
    logic busy;
    logic bothDone;

    // rising edge of the external request kicks off both lanes
    assign start = pairReq && !reqQ;

    // a faulting older instruction cancels the younger one
    assign suppress0 = fault1;

    assign bothDone = busy && done1 && done0;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            reqQ    <= 1'b0;
            busy    <= 1'b0;
            pairAck <= 1'b0;
            excpM   <= 1'b0;
        end else begin
            reqQ <= pairReq;
            if (start) begin
                busy <= 1'b1;
            end else if (bothDone) begin
                // join, results stay valid while pairAck is high
                busy    <= 1'b0;
                pairAck <= 1'b1;
                excpM   <= fault1 || fault0;
            end else if (pairAck && !pairReq) begin
                pairAck <= 1'b0;
                excpM   <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/memStage.sv
`timescale 1ns/10ps
`default_nettype none

module memStage (
    input  wire                 clk,
    input  wire                 arstN,
    input  wire                 pairReq,
    input  wire                 laneValid1,
    input  wire                 laneValid0,
    input  wire                 isLoad1,
    input  wire                 isLoad0,
    input  wire                 isStore1,
    input  wire                 isStore0,
    input  wire memPkg::msize_e size1,
    input  wire memPkg::msize_e size0,
    input  wire memPkg::word_t  addr1,
    input  wire memPkg::word_t  addr0,
    input  wire memPkg::word_t  wdata1,
    input  wire memPkg::word_t  wdata0,
    output logic                pairAck,
    output memPkg::word_t       rdata1,
    output memPkg::word_t       rdata0,
    output memPkg::excCode_e    excp1,
    output memPkg::excCode_e    excp0,
    output logic                excpM
);

    logic start;
    logic suppress0;
    logic fault1;
    logic fault0;
    logic done1;
    logic done0;

    dbusIf bus1 ();
    dbusIf bus0 ();
    dbusIf ramBus ();

    pairControl ctrl (
        .clk       (clk),
        .arstN     (arstN),
        .pairReq   (pairReq),
        .fault1    (fault1),
        .fault0    (fault0),
        .done1     (done1),
        .done0     (done0),
        .pairAck   (pairAck),
        .start     (start),
        .suppress0 (suppress0),
        .excpM     (excpM)
    );

    // older instruction, never suppressed
    memLane lane1 (
        .clk      (clk),
        .arstN    (arstN),
        .start    (start),
        .suppress (1'b0),
        .valid    (laneValid1),
        .isLoad   (isLoad1),
        .isStore  (isStore1),
        .size     (size1),
        .addr     (addr1),
        .wdata    (wdata1),
        .fault    (fault1),
        .done     (done1),
        .rdata    (rdata1),
        .excp     (excp1),
        .bus      (bus1)
    );

    memLane lane0 (
        .clk      (clk),
        .arstN    (arstN),
        .start    (start),
        .suppress (suppress0),
        .valid    (laneValid0),
        .isLoad   (isLoad0),
        .isStore  (isStore0),
        .size     (size0),
        .addr     (addr0),
        .wdata    (wdata0),
        .fault    (fault0),
        .done     (done0),
        .rdata    (rdata0),
        .excp     (excp0),
        .bus      (bus0)
    );

    dbusArbiter arb (
        .clk     (clk),
        .arstN   (arstN),
        .older   (bus1),
        .younger (bus0),
        .mem     (ramBus)
    );

    dataRam ram (
        .clk   (clk),
        .arstN (arstN),
        .port  (ramBus)
    );

endmodule

`default_nettype wire

//--- verif/memModel.sv
`timescale 1ns/10ps
`default_nettype none

`include "mem_config.svh"

module memModel;
    import memPkg::*;

    word_t    mem [`MEM_DEPTH_WORDS];
    excCode_e expExc1;
    excCode_e expExc0;
    logic     expExcM;
    word_t    expRdata1;
    word_t    expRdata0;
    logic     loaded1;
    logic     loaded0;

    initial begin
        for (int i = 0; i < `MEM_DEPTH_WORDS; i++) begin
            mem[i] = '0;
        end
    end

    // one instruction, bytes handled one at a time
    task automatic laneStep(input logic v, input logic st, input msize_e sz, input word_t a,
                            input word_t d, input logic squash, output excCode_e e,
                            output word_t r, output logic loaded);
        int nBytes;
        int off;
        int w;
        nBytes = (sz == MSIZE1) ? 1 : ((sz == MSIZE2) ? 2 : 4);
        off = a % 4;
        w = (a / 4) % `MEM_DEPTH_WORDS;
        e = EXC_NONE;
        r = '0;
        loaded = 1'b0;
        if (v && !squash) begin
            if (off % nBytes != 0) begin
                e = st ? EXC_ADES : EXC_ADEL;
            end else if (st) begin
                for (int k = 0; k < nBytes; k++) begin
                    mem[w][8*(off+k) +: 8] = d[8*k +: 8];
                end
            end else begin
                for (int k = 0; k < nBytes; k++) begin
                    r[8*k +: 8] = mem[w][8*(off+k) +: 8];
                end
                loaded = 1'b1;
            end
        end
    endtask

    // program order, older lane first
    task automatic doPair(input logic v1, input logic st1, input msize_e sz1, input word_t a1,
                          input word_t d1, input logic v0, input logic st0, input msize_e sz0,
                          input word_t a0, input word_t d0);
        laneStep(v1, st1, sz1, a1, d1, 1'b0, expExc1, expRdata1, loaded1);
        laneStep(v0, st0, sz0, a0, d0, expExc1 != EXC_NONE, expExc0, expRdata0, loaded0);
        expExcM = (expExc1 != EXC_NONE) || (expExc0 != EXC_NONE);
    endtask

endmodule

`default_nettype wire

//--- verif/tbMemStage.sv
`timescale 1ns/10ps
`default_nettype none

module tbMemStage;
    import memPkg::*;

    localparam int ACK_TIMEOUT = 100;

    logic     clk;
    logic     arstN;
    logic     pairReq;
    logic     laneValid1;
    logic     laneValid0;
    logic     isLoad1;
    logic     isLoad0;
    logic     isStore1;
    logic     isStore0;
    msize_e   size1;
    msize_e   size0;
    word_t    addr1;
    word_t    addr0;
    word_t    wdata1;
    word_t    wdata0;
    logic     pairAck;
    word_t    rdata1;
    word_t    rdata0;
    excCode_e excp1;
    excCode_e excp0;
    logic     excpM;

    int    seed = 97134;
    int    checks = 0;
    int    errors = 0;
    int    tests = 0;
    int    testErrors;
    string testName;

    memStage DUT (
        .clk        (clk),
        .arstN      (arstN),
        .pairReq    (pairReq),
        .laneValid1 (laneValid1),
        .laneValid0 (laneValid0),
        .isLoad1    (isLoad1),
        .isLoad0    (isLoad0),
        .isStore1   (isStore1),
        .isStore0   (isStore0),
        .size1      (size1),
        .size0      (size0),
        .addr1      (addr1),
        .addr0      (addr0),
        .wdata1     (wdata1),
        .wdata0     (wdata0),
        .pairAck    (pairAck),
        .rdata1     (rdata1),
        .rdata0     (rdata0),
        .excp1      (excp1),
        .excp0      (excp0),
        .excpM      (excpM)
    );

    memModel model ();

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic checkWord(input string name, input word_t exp, input word_t got);
        checks++;
        assert (got === exp) else begin
            $display("ERROR at %0t ns: %s expected %h got %h", $time, name, exp, got);
            errors++;
        end
    endtask

    // returns on a falling edge with pairAck at the wanted level
    task automatic waitForAck(input logic level);
        int n;
        n = 0;
        while (pairAck !== level && n < ACK_TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (pairAck !== level) begin
            $display("timeout: pairAck did not go to %0b within %0d cycles", level, ACK_TIMEOUT);
            $display("** FAIL **");
            $finish;
        end
    endtask

    task automatic runPair(input logic v1, input logic st1, input msize_e sz1, input word_t a1,
                           input word_t d1, input logic v0, input logic st0, input msize_e sz0,
                           input word_t a0, input word_t d0);
        @(negedge clk);
        laneValid1 = v1;
        isLoad1 = !st1;
        isStore1 = st1;
        size1 = sz1;
        addr1 = a1;
        wdata1 = d1;
        laneValid0 = v0;
        isLoad0 = !st0;
        isStore0 = st0;
        size0 = sz0;
        addr0 = a0;
        wdata0 = d0;
        pairReq = 1'b1;
        waitForAck(1'b1);
        model.doPair(v1, st1, sz1, a1, d1, v0, st0, sz0, a0, d0);
        checkWord("excp1", word_t'(model.expExc1), word_t'(excp1));
        checkWord("excp0", word_t'(model.expExc0), word_t'(excp0));
        checkWord("excpM", word_t'(model.expExcM), word_t'(excpM));
        // rdata only means something for a load that really ran
        if (model.loaded1) begin
            checkWord("rdata1", model.expRdata1, rdata1);
        end
        if (model.loaded0) begin
            checkWord("rdata0", model.expRdata0, rdata0);
        end
        pairReq = 1'b0;
        waitForAck(1'b0);
    endtask

    // small address window so the lanes hit the same words
    task automatic randomPair();
        logic   v1;
        logic   v0;
        logic   st1;
        logic   st0;
        msize_e sz1;
        msize_e sz0;
        word_t  a1;
        word_t  a0;
        v1 = ($unsigned($random(seed)) % 8) != 0;
        v0 = ($unsigned($random(seed)) % 8) != 0;
        st1 = ($unsigned($random(seed)) % 2) != 0;
        st0 = ($unsigned($random(seed)) % 2) != 0;
        sz1 = msize_e'($unsigned($random(seed)) % 3);
        sz0 = msize_e'($unsigned($random(seed)) % 3);
        a1 = $unsigned($random(seed)) % 32;
        a0 = $unsigned($random(seed)) % 32;
        runPair(v1, st1, sz1, a1, $random(seed), v0, st0, sz0, a0, $random(seed));
    endtask

    task automatic beginTest(input string name);
        testName = name;
        testErrors = errors;
        tests++;
    endtask

    task automatic endTest();
        $display("test %0d %s: %0d errors", tests, testName, errors - testErrors);
    endtask

    initial begin
        arstN = 1'b0;
        pairReq = 1'b0;
        laneValid1 = 1'b0;
        laneValid0 = 1'b0;
        isLoad1 = 1'b0;
        isLoad0 = 1'b0;
        isStore1 = 1'b0;
        isStore0 = 1'b0;
        size1 = MSIZE4;
        size0 = MSIZE4;
        addr1 = '0;
        addr0 = '0;
        wdata1 = '0;
        wdata0 = '0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        arstN = 1'b1;

        beginTest("word store then load");
        runPair(1, 1, MSIZE4, 32'h10, 32'hdeadbeef, 1, 1, MSIZE4, 32'h14, 32'h12345678);
        runPair(1, 0, MSIZE4, 32'h10, 0, 1, 0, MSIZE4, 32'h14, 0);
        endTest();

        beginTest("byte and half merge");
        runPair(1, 1, MSIZE4, 32'h20, 32'h11223344, 0, 0, MSIZE4, 0, 0);
        runPair(1, 1, MSIZE1, 32'h21, 32'h000000ab, 1, 1, MSIZE2, 32'h22, 32'h0000cdef);
        runPair(1, 0, MSIZE4, 32'h20, 0, 1, 0, MSIZE1, 32'h23, 0);
        endTest();

        beginTest("misaligned load and store");
        runPair(1, 0, MSIZE4, 32'h11, 0, 0, 0, MSIZE4, 0, 0);
        runPair(0, 0, MSIZE4, 0, 0, 1, 1, MSIZE2, 32'h13, 32'h5555aaaa);
        runPair(1, 0, MSIZE4, 32'h10, 0, 1, 0, MSIZE2, 32'h12, 0);
        endTest();

        beginTest("older fault suppresses younger");
        runPair(1, 1, MSIZE2, 32'h05, 32'h0000beef, 1, 1, MSIZE4, 32'h18, 32'h87654321);
        runPair(1, 0, MSIZE4, 32'h19, 0, 1, 0, MSIZE4, 32'h18, 0);
        runPair(1, 1, MSIZE4, 32'h1c, 32'h0badf00d, 1, 0, MSIZE4, 32'h1e, 0);
        runPair(1, 0, MSIZE4, 32'h1c, 0, 1, 0, MSIZE4, 32'h18, 0);
        endTest();

        beginTest("same word store then load");
        runPair(1, 1, MSIZE4, 32'h30, 32'hcafef00d, 1, 0, MSIZE4, 32'h30, 0);
        runPair(1, 1, MSIZE1, 32'h32, 32'h0000007e, 1, 0, MSIZE2, 32'h32, 0);
        endTest();

        beginTest("no valid lane");
        runPair(0, 1, MSIZE4, 32'h30, 32'hffffffff, 0, 1, MSIZE4, 32'h10, 32'hffffffff);
        runPair(1, 0, MSIZE4, 32'h30, 0, 1, 0, MSIZE4, 32'h10, 0);
        endTest();

        beginTest("random pairs");
        repeat (300) begin
            randomPair();
        end
        endTest();

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- build.f
+incdir+include
hw/memPkg.sv
hw/dbusIf.sv
hw/memLane.sv
hw/dbusArbiter.sv
hw/dataRam.sv
hw/pairControl.sv
hw/memStage.sv
verif/memModel.sv
verif/tbMemStage.sv

//--- Bender.yml
package:
  name: mem_stage

export_include_dirs:
  - include

sources:
  # design, in compile order
  - files:
      - hw/memPkg.sv
      - hw/dbusIf.sv
      - hw/memLane.sv
      - hw/dbusArbiter.sv
      - hw/dataRam.sv
      - hw/pairControl.sv
      - hw/memStage.sv

  # testbench and reference model
  - target: test
    files:
      - verif/memModel.sv
      - verif/tbMemStage.sv
